//--- design/fp_div_pkg.sv
// fp32 srt divider shared definitions
// operand classes, exception flags, the registered operand bundle,
// quotient digit encoding and fixed format constants
`default_nettype none

package fp_div_pkg;

    localparam int man_w     = 24;            // mantissa incl hidden bit
    localparam int srt_iters = 14;            // radix-4 steps, 2 bits each
    localparam int exp_bias  = 127;
    localparam logic [31:0] qnan = 32'h7fc0_0000;   // canonical quiet nan

    // class of one operand, subnormals count as normal after normalization
    typedef enum logic [1:0] {
        cls_zero   = 2'd0,
        cls_normal = 2'd1,
        cls_inf    = 2'd2,
        cls_nan    = 2'd3
    } fp_class_t;

    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    // everything the datapath needs after the unpack stage
    typedef struct packed {
        logic              sign;        // sign_a ^ sign_b
        logic signed [9:0] exp_diff;    // ea - eb + bias, before quotient normalization
        logic [man_w-1:0]  man_a;       // 1.xxx
        logic [man_w-1:0]  man_b;       // 1.xxx
        fp_class_t         cls_a;
        fp_class_t         cls_b;
    } div_operands_t;

    // sign-magnitude digit in -2..2
    // [2] sign, [1:0] magnitude
    typedef logic [2:0] srt_digit_t;

endpackage

`default_nettype wire

//--- design/div_normalizer.sv
// operand unpack stage of the fp32 divider
// classifies both operands, left-justifies subnormal mantissas with a
// leading zero count and registers sign, exponent difference and mantissas
`default_nettype none
`timescale 1ns/100ps

module div_normalizer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [31:0]               dividend,
    input  logic [31:0]               divisor,
    output fp_div_pkg::div_operands_t ops
);

    localparam int mw = fp_div_pkg::man_w;

    fp_div_pkg::fp_class_t     cls_a;
    fp_div_pkg::fp_class_t     cls_b;
    logic [mw-1:0]             man_a;
    logic [mw-1:0]             man_b;
    logic signed [9:0]         exp_a;
    logic signed [9:0]         exp_b;
    fp_div_pkg::div_operands_t ops_d;

    function automatic logic [4:0] lead_zeros(input logic [mw-1:0] m);
        logic [4:0] n;
        logic       hit;
        n   = '0;
        hit = 1'b0;
        for (int i = mw - 1; i >= 0; i--) begin
            if (m[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 5'd1;     // still in the leading zero run
        end
        return n;
    endfunction

    function automatic fp_div_pkg::fp_class_t classify(input logic [31:0] f);
        if (f[30:23] == 8'hff)
            return (f[22:0] != '0) ? fp_div_pkg::cls_nan : fp_div_pkg::cls_inf;
        if (f[30:0] == '0)
            return fp_div_pkg::cls_zero;
        return fp_div_pkg::cls_normal;
    endfunction

    // hidden bit only when the exponent field is nonzero
    function automatic logic [mw-1:0] norm_man(input logic [31:0] f);
        logic [mw-1:0] m;
        m = {(f[30:23] != 8'd0), f[22:0]};
        return m << lead_zeros(m);   // no shift for normals
    endfunction

    // subnormal: effective exponent 1, minus the normalizing shift
    function automatic logic signed [9:0] norm_exp(input logic [31:0] f);
        logic [mw-1:0] m;
        m = {1'b0, f[22:0]};
        if (f[30:23] == 8'd0)
            return 10'sd1 - 10'(lead_zeros(m));
        return 10'(f[30:23]);
    endfunction

    assign cls_a = classify(dividend);
    assign cls_b = classify(divisor);
    // zero, inf and nan run the iteration on 1.0 so the recurrence stays bounded
    assign man_a = (cls_a == fp_div_pkg::cls_normal) ? norm_man(dividend) : {1'b1, 23'd0};
    assign man_b = (cls_b == fp_div_pkg::cls_normal) ? norm_man(divisor) : {1'b1, 23'd0};
    assign exp_a = norm_exp(dividend);
    assign exp_b = norm_exp(divisor);

    always_comb begin
        ops_d.sign     = dividend[31] ^ divisor[31];
        ops_d.exp_diff = exp_a - exp_b + 10'(fp_div_pkg::exp_bias);
        ops_d.man_a    = man_a;
        ops_d.man_b    = man_b;
        ops_d.cls_a    = cls_a;
        ops_d.cls_b    = cls_b;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            ops <= '0;            // both classes read as zero
        else if (start)
            ops <= ops_d;         // held until the next accepted start
    end

    // a loaded normal operand always reaches the iteration left-justified
    assert property (@(posedge clk) disable iff (!rst)
        start |=> ((ops.cls_a != fp_div_pkg::cls_normal) || ops.man_a[mw-1]) &&
                  ((ops.cls_b != fp_div_pkg::cls_normal) || ops.man_b[mw-1]));

endmodule

`default_nettype wire

//--- design/srt4_qds.sv
// radix-4 quotient digit selection, digit set -2..2
// estimate is the shifted remainder in quarter units (5 bit, signed),
// divisor interval from the 4 bits after the leading one
`default_nettype none
`timescale 1ns/100ps

module srt4_qds (
    input  logic [4:0]             r_idx,
    input  logic [3:0]             d_idx,
    output fp_div_pkg::srt_digit_t digit
);

    logic signed [4:0] est;   // 4w estimate, lsb = 1/4
    logic signed [4:0] m1;    // threshold between 0 and +1
    logic signed [4:0] m2;    // threshold between +1 and +2

    assign est = r_idx;

    // per divisor interval [dl, dl+1/16)
    // m1 in [dh/3, 2dl/3], m2 in [4dh/3, 5dl/3], both in quarter units
    // negative side is symmetric, so -m1 and -m2 bound -1 and -2
    always_comb begin
        m1 = d_idx[3] ? 5'sd3 : 5'sd2;       // 0.75 above d = 1.5, else 0.5
        case (d_idx)
            4'd0, 4'd1:        m2 = 5'sd6;   // 1.50
            4'd2, 4'd3, 4'd4:  m2 = 5'sd7;   // 1.75
            4'd5, 4'd6, 4'd7:  m2 = 5'sd8;   // 2.00
            4'd8, 4'd9:        m2 = 5'sd9;   // 2.25
            4'd10, 4'd11:      m2 = 5'sd10;  // 2.50
            4'd12, 4'd13,
            4'd14:             m2 = 5'sd11;  // 2.75
            default:           m2 = 5'sd12;  // 3.00, d in [1.9375, 2)
        endcase
    end

    // truncation error of est is in [0, 1/4), covered by the
    // overlap of the selection intervals (at least d/3 - 1/12)
    always_comb begin
        if (est >= m2)
            digit = 3'b010;       // +2
        else if (est >= m1)
            digit = 3'b001;       // +1
        else if (est >= -m1)
            digit = 3'b000;       // 0
        else if (est >= -m2)
            digit = 3'b101;       // -1
        else
            digit = 3'b110;       // -2
    end

endmodule

`default_nettype wire

//--- design/srt4_iteration.sv
// radix-4 srt iteration unit
// keeps the partial remainder, picks one digit per clock from the
// selection table and assembles the quotient by on-the-fly conversion
// (q and q-1), flags the last of srt_iters steps
`default_nettype none
`timescale 1ns/100ps

module srt4_iteration #(
    parameter int man_w = 24
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load,
    input  logic [man_w-1:0]                    dividend_man,
    input  logic [man_w-1:0]                    divisor_man,
    output logic [2*fp_div_pkg::srt_iters-1:0]  q_pos,
    output logic [2*fp_div_pkg::srt_iters-1:0]  q_neg,
    output logic signed [man_w+1:0]             rem,
    output logic                                last
);

    localparam int qw = 2 * fp_div_pkg::srt_iters;
    localparam int cw = $clog2(fp_div_pkg::srt_iters + 1);

    // remainder lsb at 2^-25 sits two bits below the divisor lsb
    // so the initial x/4 is exact
    logic signed [man_w+2:0] w_q;      // w with |w| <= 2d/3
    logic signed [man_w+4:0] w_sh;     // 4w
    logic signed [man_w+4:0] d_one;    // d at remainder scale
    logic signed [man_w+4:0] d_mult;   // |digit| * d
    logic signed [man_w+4:0] w_next;
    logic [man_w+4:0]        w_abs;    // |4w| for the bound check
    logic signed [5:0]       est_full; // 4w in quarter units
    logic [4:0]              r_idx;
    fp_div_pkg::srt_digit_t  digit;
    logic [qw-1:0]           q_next;
    logic [qw-1:0]           qm_next;
    logic [cw-1:0]           cnt;      // iterations left
    logic                    run;

    assign run   = (cnt != '0);
    assign w_sh  = {w_q, 2'b00};
    assign d_one = {3'b000, divisor_man, 2'b00};
    assign w_abs = w_sh[man_w+4] ? -w_sh : w_sh;

    // top bits of 4w saturated to the 5 bit table range
    // anything past +-3.75 selects +-2 anyway
    assign est_full = w_sh[man_w+4:man_w-1];
    always_comb begin
        if (est_full > 6'sd15)
            r_idx = 5'b01111;
        else if (est_full < -6'sd16)
            r_idx = 5'b10000;
        else
            r_idx = est_full[4:0];
    end

    srt4_qds u_qds (
        .r_idx (r_idx),
        .d_idx (divisor_man[man_w-2 -: 4]),   // 4 bits after the leading one
        .digit (digit)
    );

    // 0, d or 2d
    assign d_mult = digit[1] ? (d_one <<< 1) : (digit[0] ? d_one : '0);
    // positive digit subtracts, negative adds
    assign w_next = digit[2] ? (w_sh + d_mult) : (w_sh - d_mult);

    // on-the-fly conversion
    always_comb begin
        if (!digit[2])
            q_next = {q_pos[qw-3:0], digit[1:0]};
        else
            q_next = {q_neg[qw-3:0], 2'b00 - digit[1:0]};   // borrow via qm gives 4-|q|
        if (!digit[2] && (digit[1:0] != 2'b00))
            qm_next = {q_pos[qw-3:0], digit[1:0] - 2'b01};
        else
            qm_next = {q_neg[qw-3:0], ~digit[1:0]};          // 3-|q|
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt  <= '0;
            last <= 1'b0;
        end else if (load) begin
            cnt  <= cw'(fp_div_pkg::srt_iters);
            last <= 1'b0;
        end else begin
            if (run)
                cnt <= cnt - 1'b1;
            last <= (cnt == cw'(1));   // final step lands this edge
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            w_q   <= {3'b000, dividend_man};   // x/4 at 2^-25 scale
            q_pos <= '0;
            q_neg <= '1;                       // q - 1 = -1
        end else if (run) begin
            w_q   <= w_next[man_w+2:0];
            q_pos <= q_next;
            q_neg <= qm_next;
        end
    end

    // after the first step w has no bits below the divisor lsb
    assign rem = {w_q[man_w+2], w_q[man_w+2:2]};

    // shifted remainder stays within +-(2/3)*4d so the table never picks wrong
    assert property (@(posedge clk) disable iff (!rst)
        run |-> (3 * w_abs <= 8 * $unsigned(d_one)));

endmodule

`default_nettype wire

//--- design/div_post_processing.sv
// result stage of the fp32 divider
// last-digit correction, normalization to 1.xxx, round to nearest even,
// range checks with flush to zero, special operand results and flags
`default_nettype none
`timescale 1ns/100ps

module div_post_processing (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      last,
    input  fp_div_pkg::div_operands_t ops,
    input  logic [27:0]               q_pos,
    input  logic [27:0]               q_neg,
    input  logic signed [25:0]        rem,
    output logic [31:0]               quotient,
    output fp_div_pkg::fp_flags_t     flags,
    output logic                      done
);

    logic [27:0]           q_sel;       // value = q_sel / 2^26
    logic [23:0]           man;
    logic                  guard;
    logic                  round_bit;
    logic                  sticky;
    logic                  round_up;
    logic [24:0]           man_rnd;     // carry out in [24]
    logic signed [10:0]    exp_norm;
    logic signed [10:0]    exp_rnd;
    logic                  any_nan;
    logic                  a_zero;
    logic                  b_zero;
    logic                  a_inf;
    logic                  b_inf;
    logic [31:0]           res;
    fp_div_pkg::fp_flags_t res_flags;

    // negative remainder means the last digit was one too big
    assign q_sel = rem[25] ? q_neg : q_pos;

    always_comb begin
        if (q_sel[26]) begin           // quotient in [1, 2)
            man       = q_sel[26:3];
            guard     = q_sel[2];
            round_bit = q_sel[1];
            sticky    = q_sel[0] | (rem != '0);
            exp_norm  = {ops.exp_diff[9], ops.exp_diff};
        end else begin                 // in (0.5, 1), one left shift
            man       = q_sel[25:2];
            guard     = q_sel[1];
            round_bit = q_sel[0];
            sticky    = (rem != '0);
            exp_norm  = {ops.exp_diff[9], ops.exp_diff} - 11'sd1;
        end
    end

    // nearest even
    assign round_up = guard & (round_bit | sticky | man[0]);
    assign man_rnd  = {1'b0, man} + 25'(round_up);
    assign exp_rnd  = exp_norm + {10'd0, man_rnd[24]};   // 1.111..1 rolls to 10.0

    assign any_nan = (ops.cls_a == fp_div_pkg::cls_nan) || (ops.cls_b == fp_div_pkg::cls_nan);
    assign a_zero  = (ops.cls_a == fp_div_pkg::cls_zero);
    assign b_zero  = (ops.cls_b == fp_div_pkg::cls_zero);
    assign a_inf   = (ops.cls_a == fp_div_pkg::cls_inf);
    assign b_inf   = (ops.cls_b == fp_div_pkg::cls_inf);

    always_comb begin
        res_flags = '0;
        res       = {ops.sign, exp_rnd[7:0], man_rnd[22:0]};   // frac is 0 after carry out
        if (any_nan) begin
            res = fp_div_pkg::qnan;
        end else if ((a_zero && b_zero) || (a_inf && b_inf)) begin
            res               = fp_div_pkg::qnan;
            res_flags.invalid = 1'b1;
        end else if (b_zero) begin
            res                   = {ops.sign, 8'hff, 23'd0};
            res_flags.div_by_zero = 1'b1;
        end else if (a_zero || b_inf) begin
            res = {ops.sign, 31'd0};
        end else if (a_inf) begin
            res = {ops.sign, 8'hff, 23'd0};
        end else if (exp_rnd >= 11'sd255) begin
            res                = {ops.sign, 8'hff, 23'd0};   // overflow to inf
            res_flags.overflow = 1'b1;
            res_flags.inexact  = 1'b1;
        end else if (exp_rnd <= 11'sd0) begin
            res                 = {ops.sign, 31'd0};        // flush, no subnormal output
            res_flags.underflow = 1'b1;
            res_flags.inexact   = 1'b1;
        end else begin
            res_flags.inexact = guard | round_bit | sticky;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            quotient <= '0;
            flags    <= '0;
            done     <= 1'b0;
        end else begin
            done <= last;
            if (last) begin
                quotient <= res;
                flags    <= res_flags;
            end
        end
    end

    // one division in flight, so results never come back to back
    assert property (@(posedge clk) disable iff (!rst) done |=> !done);

endmodule

`default_nettype wire

//--- design/srt_divider_fp32.sv
// ieee 754 single precision divider, radix-4 srt
// fixed 16 cycle schedule: unpack, 14 iterations, round and pack
// start is ignored while a division is in flight
`default_nettype none
`timescale 1ns/100ps

module srt_divider_fp32 #(
    parameter int man_w = fp_div_pkg::man_w
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [31:0]           dividend,
    input  logic [31:0]           divisor,
    output logic [31:0]           quotient,
    output fp_div_pkg::fp_flags_t flags,
    output logic                  done
);

    localparam int qw = 2 * fp_div_pkg::srt_iters;

    fp_div_pkg::div_operands_t ops;
    logic                      start_acc;   // start that begins a division
    logic                      busy;
    logic                      load;        // start delayed one cycle
    logic                      last;
    logic [qw-1:0]             q_pos;
    logic [qw-1:0]             q_neg;
    logic signed [man_w+1:0]   rem;

    // a new start may already land in the done cycle
    assign start_acc = start & (~busy | done);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            load <= 1'b0;
        end else begin
            load <= start_acc;
            if (start_acc)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    div_normalizer u_norm (
        .clk      (clk),
        .rst      (rst),
        .start    (start_acc),
        .dividend (dividend),
        .divisor  (divisor),
        .ops      (ops)
    );

    srt4_iteration #(
        .man_w (man_w)
    ) u_iter (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .dividend_man (ops.man_a),
        .divisor_man  (ops.man_b),
        .q_pos        (q_pos),
        .q_neg        (q_neg),
        .rem          (rem),
        .last         (last)
    );

    div_post_processing u_post (
        .clk      (clk),
        .rst      (rst),
        .last     (last),
        .ops      (ops),
        .q_pos    (q_pos),
        .q_neg    (q_neg),
        .rem      (rem),
        .quotient (quotient),
        .flags    (flags),
        .done     (done)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// clock and reset source for the divider testbench
// free running clock, active low reset held for a fixed number of cycles
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b0;                            // in reset from time zero
        repeat (reset_cycles) @(posedge clk);
        #5 rst = 1'b1;                         // release clear of the edge
    end

endmodule

`default_nettype wire

//--- testbench/tb_fp_div_ref.svh
// reference model for fp32 division, integer arithmetic only
// exact 64 bit quotient, round to nearest even, flush to zero,
// special operands; returns {quotient, flags}
`ifndef TB_FP_DIV_REF_SVH
`define TB_FP_DIV_REF_SVH
`default_nettype none

function automatic logic [36:0] ref_fp_div(input logic [31:0] a, input logic [31:0] b);
    logic        sign;
    logic        a_nan;
    logic        b_nan;
    logic        a_inf;
    logic        b_inf;
    logic        a_zero;
    logic        b_zero;
    logic [23:0] ma;
    logic [23:0] mb;
    int          ea;
    int          eb;
    int          e;
    logic [63:0] num;
    logic [63:0] quo;
    logic [63:0] rmd;
    logic [23:0] man;
    logic        g;
    logic        rb;
    logic        st;
    logic        up;
    logic [24:0] mr;                              // carry out in [24]
    logic [31:0] res;
    logic [4:0]  fl;                              // inv, dbz, ovf, unf, inx
    sign   = a[31] ^ b[31];
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
    b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
    a_zero = (a[30:0] == 31'd0);
    b_zero = (b[30:0] == 31'd0);
    fl     = 5'b00000;
    if (a_nan || b_nan) begin
        res = 32'h7fc0_0000;
    end else if ((a_zero && b_zero) || (a_inf && b_inf)) begin
        res = 32'h7fc0_0000;
        fl  = 5'b10000;
    end else if (b_zero) begin
        res = {sign, 8'hff, 23'd0};
        fl  = 5'b01000;
    end else if (a_zero || b_inf) begin
        res = {sign, 31'd0};
    end else if (a_inf) begin
        res = {sign, 8'hff, 23'd0};
    end else begin
        // subnormals: no hidden bit, exponent 1, then shift up to 1.xxx
        ma = {a[30:23] != 8'd0, a[22:0]};
        mb = {b[30:23] != 8'd0, b[22:0]};
        ea = (a[30:23] == 8'd0) ? 1 : int'(a[30:23]);
        eb = (b[30:23] == 8'd0) ? 1 : int'(b[30:23]);
        for (int i = 0; i < 23; i++) begin
            if (!ma[23]) begin
                ma = ma << 1;
                ea = ea - 1;
            end
            if (!mb[23]) begin
                mb = mb << 1;
                eb = eb - 1;
            end
        end
        num = 64'(ma) << 26;                      // quotient lsb at 2^-26
        quo = num / 64'(mb);
        rmd = num % 64'(mb);
        e   = ea - eb + 127;
        if (quo[26]) begin
            man = quo[26:3];
            g   = quo[2];
            rb  = quo[1];
            st  = quo[0] || (rmd != 64'd0);
        end else begin                            // below one, renormalize
            man = quo[25:2];
            g   = quo[1];
            rb  = quo[0];
            st  = (rmd != 64'd0);
            e   = e - 1;
        end
        up = g && (rb || st || man[0]);
        mr = {1'b0, man} + 25'(up);
        if (mr[24])
            e = e + 1;
        if (e >= 255) begin
            res = {sign, 8'hff, 23'd0};
            fl  = 5'b00101;
        end else if (e <= 0) begin
            res = {sign, 31'd0};                  // flushed
            fl  = 5'b00011;
        end else begin
            res = {sign, 8'(e), mr[22:0]};
            fl  = {4'b0000, g | rb | st};
        end
    end
    return {res, fl};
endfunction

`default_nettype wire
`endif

//--- testbench/tb_srt_divider_fp32.sv
// testbench for the fp32 srt divider
// exact, random, subnormal, range and special divisions against an
// integer reference, plus fixed latency and busy start handling
`default_nettype none
`timescale 1ns/100ps

module tb_srt_divider_fp32;

    localparam int n_random = 2000;
    localparam int n_sub    = 16;
    localparam int n_tests  = 3 + n_random + 4 + n_sub + 5 + 10 + 1;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic [31:0]           dividend;
    logic [31:0]           divisor;
    logic [31:0]           quotient;
    fp_div_pkg::fp_flags_t flags;
    logic                  done;

    integer      seed;
    int          errors   = 0;
    int          cycle    = 0;    // rising edges so far
    int          n_issued = 0;
    int          n_done   = 0;
    logic [36:0] exp_q[$];        // {quotient, flags} per accepted start
    int          start_q[$];      // edge count of the sampling edge
    logic [36:0] expected;
    int          issued_at;
    logic [31:0] op_a;
    logic [31:0] op_b;

    tb_clock_gen #(
        .period_ns    (100),
        .reset_cycles (10)
    ) clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    srt_divider_fp32 #(
        .man_w (fp_div_pkg::man_w)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .quotient (quotient),
        .flags    (flags),
        .done     (done)
    );

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (got !== want) begin
            errors++;
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    // one cycle strobe 5 ns after the edge
    task automatic pulse_start(input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        #5;
        start    = 1'b1;
        dividend = a;
        divisor  = b;
        @(posedge clk);
        #5;
        start = 1'b0;
    endtask

    task automatic run_division(input logic [31:0] a, input logic [31:0] b,
                                input logic [36:0] want);
        pulse_start(a, b);
        exp_q.push_back(want);
        start_q.push_back(cycle);             // edge that took the start
        n_issued++;
        while (n_done < n_issued)
            @(posedge clk);
    endtask

    function automatic logic [31:0] random_normal(input int e_lo, input int e_span);
        logic [31:0] r;
        int          e;
        r = $random(seed);
        e = e_lo + int'({$random(seed)} % e_span);
        return {r[31], 8'(e), r[22:0]};
    endfunction

    // compare each done against the oldest accepted start
    always @(negedge clk) begin
        if (done) begin
            n_done++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected done pulse at %0d ns, no division in flight", $time);
            end else begin
                expected  = exp_q.pop_front();
                issued_at = start_q.pop_front();
                check_value("quotient", expected[36:5], quotient);
                check_value("flags", {27'd0, expected[4:0]}, {27'd0, flags});
                check_value("done latency", 32'd16, 32'(cycle - issued_at));
            end
        end
    end

    initial begin
        seed     = 32'h8d0b_eae3;
        start    = 1'b0;
        dividend = '0;
        divisor  = '0;
        @(posedge rst);
        run_division(32'h40c0_0000, 32'h4040_0000, {32'h4000_0000, 5'b00000});  // 6/3
        run_division(32'h3f80_0000, 32'h4080_0000, {32'h3e80_0000, 5'b00000});  // 1/4
        run_division(32'hc0e0_0000 ^ 32'h8000_0000, 32'hc000_0000,
                     {32'hc060_0000, 5'b00000});                                 // 7/-2
        for (int i = 0; i < n_random; i++) begin
            op_a = (i % 4 == 0) ? random_normal(1, 254) : random_normal(96, 64);
            op_b = (i % 4 == 0) ? random_normal(1, 254) : random_normal(96, 64);
            run_division(op_a, op_b, ref_fp_div(op_a, op_b));
        end
        // subnormal operands
        run_division(32'h0000_0001, 32'h0080_0000, {32'h3400_0000, 5'b00000});
        run_division(32'h0040_0000, 32'h3f00_0000, {32'h0080_0000, 5'b00000});
        run_division(32'h3f80_0000, 32'h0040_0000, {32'h7f00_0000, 5'b00000});
        run_division(32'h8000_0003, 32'h3f80_0000, {32'h8000_0000, 5'b00011});
        for (int i = 0; i < n_sub; i++) begin
            op_a = (i % 2 == 0) ? ($random(seed) & 32'h807f_ffff) : random_normal(60, 40);
            op_b = (i % 2 == 0) ? random_normal(1, 40) : ($random(seed) & 32'h807f_ffff);
            run_division(op_a, op_b, ref_fp_div(op_a, op_b));
        end
        // out of range
        run_division(32'h7f00_0000, 32'h3e80_0000, {32'h7f80_0000, 5'b00101});
        run_division(32'hff7f_ffff, 32'h3f00_0000, {32'hff80_0000, 5'b00101});
        run_division(32'h7f7f_ffff, 32'h3f7f_ffff, {32'h7f80_0000, 5'b00101});  // exactly 2^128
        run_division(32'h0080_0000, 32'h4000_0000, {32'h0000_0000, 5'b00011});
        run_division(32'h8080_0000, 32'h4b00_0000, {32'h8000_0000, 5'b00011});
        // special operands
        run_division(32'h0000_0000, 32'h8000_0000, {32'h7fc0_0000, 5'b10000});  // 0/0
        run_division(32'h7f80_0000, 32'hff80_0000, {32'h7fc0_0000, 5'b10000});  // inf/inf
        run_division(32'h7fc0_0001, 32'h3f80_0000, {32'h7fc0_0000, 5'b00000});
        run_division(32'h3f80_0000, 32'hffc1_2345, {32'h7fc0_0000, 5'b00000});
        run_division(32'h3f80_0000, 32'h0000_0000, {32'h7f80_0000, 5'b01000});  // x/0
        run_division(32'hbf80_0000, 32'h0000_0000, {32'hff80_0000, 5'b01000});
        run_division(32'h8000_0000, 32'h4000_0000, {32'h8000_0000, 5'b00000});  // 0/x
        run_division(32'h0000_0000, 32'h7f80_0000, {32'h0000_0000, 5'b00000});
        run_division(32'h4000_0000, 32'hff80_0000, {32'h8000_0000, 5'b00000});  // x/inf
        run_division(32'hff80_0000, 32'hc000_0000, {32'h7f80_0000, 5'b00000});  // inf/x
        // second start while busy must be dropped
        pulse_start(32'h40c0_0000, 32'h4040_0000);
        exp_q.push_back({32'h4000_0000, 5'b00000});
        start_q.push_back(cycle);
        n_issued++;
        repeat (2) @(posedge clk);
        pulse_start(32'h3f80_0000, 32'h4080_0000);
        while (n_done < n_issued)
            @(posedge clk);
        repeat (10) @(posedge clk);              // window for a stray done
        $display("%0d errors, %0d divisions, %0d done pulses", errors, n_issued, n_done);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        repeat (n_tests * 20 + 50) @(posedge clk);
        $display("timeout: the divider did not complete %0d divisions in time", n_tests);
        $display("Finished with errors");
        $finish;
    end

`include "tb_fp_div_ref.svh"

endmodule

`default_nettype wire

//--- srt_divider_fp32.f
+incdir+testbench
design/fp_div_pkg.sv
design/div_normalizer.sv
design/srt4_qds.sv
design/srt4_iteration.sv
design/div_post_processing.sv
design/srt_divider_fp32.sv
testbench/tb_clock_gen.sv
testbench/tb_srt_divider_fp32.sv

//--- Makefile
TOP = tb_srt_divider_fp32

.PHONY: all build lint clean

# build, run, and pass only if the testbench prints its pass line
all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f srt_divider_fp32.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f srt_divider_fp32.f --top-module srt_divider_fp32

clean:
	rm -rf obj_dir
